//--- Bender.yml
package:
  name: rv_hart

sources:
  - src/rv_pkg.sv
  - src/inst_decode.sv
  - src/reg_file.sv
  - src/alu.sv
  - src/result_stage.sv
  - src/rv_hart.sv
  - target: simulation
    files:
      - sim/tb_rv_hart.sv

//--- flist.f
src/rv_pkg.sv
src/inst_decode.sv
src/reg_file.sv
src/alu.sv
src/result_stage.sv
src/rv_hart.sv
sim/tb_rv_hart.sv

//--- sim/hart_vectors.txt
// inst     load     pc       next_pc  rd rd_wdata dmem_adr r w dmem_wdat (all hex)
// One executed instruction per line, register values carry from line to line
FFB00093 00000000 00000000 00000004 01 FFFFFFFB 00000000 0 0 00000000 // addi x1, x0, -5
00300113 00000000 00000004 00000008 02 00000003 00000000 0 0 00000000 // addi x2, x0, 3
002081B3 00000000 00000008 0000000C 03 FFFFFFFE 00000000 0 0 00000000 // add x3, x1, x2
40110233 00000000 0000000C 00000010 04 00000008 00000000 0 0 00000000 // sub x4, x2, x1
4020D2B3 00000000 00000010 00000014 05 FFFFFFFF 00000000 0 0 00000000 // sra x5, x1, x2
0020D333 00000000 00000014 00000018 06 1FFFFFFF 00000000 0 0 00000000 // srl x6, x1, x2
0020A3B3 00000000 00000018 0000001C 07 00000001 00000000 0 0 00000000 // slt x7, x1, x2
0020B433 00000000 0000001C 00000020 08 00000000 00000000 0 0 00000000 // sltu x8, x1, x2
FFC0A493 00000000 00000020 00000024 09 00000001 00000000 0 0 00000000 // slti x9, x1, -4
00F0C513 00000000 00000024 00000028 0A FFFFFFF4 00000000 0 0 00000000 // xori x10, x1, 0xf
4010D593 00000000 00000028 0000002C 0B FFFFFFFD 00000000 0 0 00000000 // srai x11, x1, 1
0040F633 00000000 0000002C 00000030 0C 00000008 00000000 0 0 00000000 // and x12, x1, x4
002116B3 00000000 00000030 00000034 0D 00000018 00000000 0 0 00000000 // sll x13, x2, x2
00710013 00000000 00000034 00000038 00 00000000 00000000 0 0 00000000 // addi x0, x2, 7
00200733 00000000 00000038 0000003C 0E 00000003 00000000 0 0 00000000 // add x14, x0, x2
123457B7 00000000 0000003C 00000040 0F 12345000 00000000 0 0 00000000 // lui x15, 0x12345
00001817 00000000 00000040 00000044 10 00001040 00000000 0 0 00000000 // auipc x16, 0x1
0047A623 00000000 00000044 00000048 00 00000000 1234500C 0 1 00000008 // sw x4, 12(x15)
FFC7A883 CAFEF00D 00000048 0000004C 11 CAFEF00D 12344FFC 1 0 00000000 // lw x17, -4(x15)
00288933 00000000 0000004C 00000050 12 CAFEF010 00000000 0 0 00000000 // add x18, x17, x2
00E10463 00000000 00000050 00000058 00 00000000 00000000 0 0 00000000 // beq x2, x14 taken
00E11463 00000000 00000058 0000005C 00 00000000 00000000 0 0 00000000 // bne x2, x14 not
0020C463 00000000 0000005C 00000064 00 00000000 00000000 0 0 00000000 // blt x1, x2 taken
0020D463 00000000 00000064 00000068 00 00000000 00000000 0 0 00000000 // bge x1, x2 not
0020E463 00000000 00000068 0000006C 00 00000000 00000000 0 0 00000000 // bltu x1, x2 not
0020F463 00000000 0000006C 00000074 00 00000000 00000000 0 0 00000000 // bgeu x1, x2 taken
00208463 00000000 00000074 00000078 00 00000000 00000000 0 0 00000000 // beq x1, x2 not
00114463 00000000 00000078 0000007C 00 00000000 00000000 0 0 00000000 // blt x2, x1 not
00116463 00000000 0000007C 00000084 00 00000000 00000000 0 0 00000000 // bltu x2, x1 taken
00115463 00000000 00000084 0000008C 00 00000000 00000000 0 0 00000000 // bge x2, x1 taken
00117463 00000000 0000008C 00000090 00 00000000 00000000 0 0 00000000 // bgeu x2, x1 not
00200993 00000000 00000090 00000094 13 00000002 00000000 0 0 00000000 // addi x19, x0, 2
FFF98993 00000000 00000094 00000098 13 00000001 00000000 0 0 00000000 // addi x19, x19, -1
FE099EE3 00000000 00000098 00000094 00 00000000 00000000 0 0 00000000 // bne x19, x0, -4
FFF98993 00000000 00000094 00000098 13 00000000 00000000 0 0 00000000 // addi x19, x19, -1
FE099EE3 00000000 00000098 0000009C 00 00000000 00000000 0 0 00000000 // bne x19, x0, -4
00B02223 00000000 0000009C 000000A0 00 00000000 00000004 0 1 FFFFFFFD // sw x11, 4(x0)

//--- sim/tb_rv_hart.sv
// Testbench for the single-cycle RV32I core
// Replays sim/hart_vectors.txt one line per clock. Each line supplies the
// fetched instruction and the load data together with the expected retire
// and data memory outputs. Run from the project root with flist.f.

`timescale 1ns/1ps

module tb_rv_hart import rv_pkg::*; ();

    localparam int              CLK_PERIOD = 8;
    localparam int              NUM_FIELDS = 10;     // Columns per vector line
    localparam int              MAX_VEC    = 64;
    localparam logic [XLEN-1:0] RESET_ADDR = '0;
    localparam logic [XLEN-1:0] IDLE_STORE = 32'h0047A623;  // sw x4, 12(x15)
    localparam logic [XLEN-1:0] IDLE_LOAD  = 32'hFFC7A883;  // lw x17, -4(x15)

    logic                  clk;
    logic                  rst_n;
    logic [XLEN-1:0]       imem_raddr;
    logic [XLEN-1:0]       imem_rdata;
    logic [XLEN-1:0]       dmem_addr;
    logic                  dmem_ren;
    logic                  dmem_wen;
    logic [XLEN-1:0]       dmem_wdata;
    logic [XLEN-1:0]       dmem_rdata;
    logic                  retire_valid;
    logic [XLEN-1:0]       retire_inst;
    logic [XLEN-1:0]       retire_pc;
    logic [XLEN-1:0]       retire_next_pc;
    logic [REG_ADDR_W-1:0] retire_rd_waddr;
    logic [XLEN-1:0]       retire_rd_wdata;

    logic [XLEN-1:0] vec_mem [0:MAX_VEC*NUM_FIELDS-1];   // Flat, NUM_FIELDS words per line
    int              num_vec;
    bit              loaded;
    int              err_count;
    int              tests_passed;
    int              tests_failed;

    rv_hart #(.RESET_ADDR(RESET_ADDR)) i_rv_hart (
        .clk(clk), .rst_n(rst_n),
        .o_imem_raddr(imem_raddr), .i_imem_rdata(imem_rdata),
        .o_dmem_addr(dmem_addr), .o_dmem_ren(dmem_ren), .o_dmem_wen(dmem_wen),
        .o_dmem_wdata(dmem_wdata), .i_dmem_rdata(dmem_rdata),
        .o_retire_valid(retire_valid), .o_retire_inst(retire_inst),
        .o_retire_pc(retire_pc), .o_retire_next_pc(retire_next_pc),
        .o_retire_rd_waddr(retire_rd_waddr), .o_retire_rd_wdata(retire_rd_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [XLEN-1:0] to_word(input logic b);
        return {{(XLEN-1){1'b0}}, b};
    endfunction

    task automatic compare_word(input string name, input logic [XLEN-1:0] got,
                                input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("ERROR %0t ns: %s is %h, expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            tests_passed++;
            $display("%s: pass", name);
        end else begin
            tests_failed++;
            $display("%s: FAIL", name);
        end
    endtask

    // Compares all retire and dmem outputs against line n
    task automatic check_outputs(input int n, input logic [XLEN-1:0] prev_next);
        int base;
        base = n * NUM_FIELDS;
        compare_word("retire_valid", to_word(retire_valid), to_word(1'b1));
        compare_word("retire_inst", retire_inst, vec_mem[base]);
        compare_word("imem_raddr", imem_raddr, vec_mem[base + 2]);
        compare_word("retire_pc", retire_pc, vec_mem[base + 2]);
        if (n == 0) begin
            compare_word("first retired pc", retire_pc, RESET_ADDR);
        end else begin
            compare_word("pc versus previous next_pc", retire_pc, prev_next);
        end
        compare_word("retire_next_pc", retire_next_pc, vec_mem[base + 3]);
        compare_word("retire_rd_waddr", {{(XLEN-REG_ADDR_W){1'b0}}, retire_rd_waddr},
                     vec_mem[base + 4]);
        if (vec_mem[base + 4] != '0) begin              // Data only means something on a write
            compare_word("retire_rd_wdata", retire_rd_wdata, vec_mem[base + 5]);
        end
        compare_word("dmem_ren", to_word(dmem_ren), vec_mem[base + 7]);
        compare_word("dmem_wen", to_word(dmem_wen), vec_mem[base + 8]);
        if (vec_mem[base + 7] != '0 || vec_mem[base + 8] != '0) begin
            compare_word("dmem_addr", dmem_addr, vec_mem[base + 6]);
        end
        if (vec_mem[base + 8] != '0) begin
            compare_word("dmem_wdata", dmem_wdata, vec_mem[base + 9]);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        int              errs;
        logic [XLEN-1:0] last_next_pc;
        rst_n        = 1'b0;
        imem_rdata   = '0;
        dmem_rdata   = '0;
        err_count    = 0;
        tests_passed = 0;
        tests_failed = 0;
        num_vec      = 0;
        last_next_pc = '0;
        $readmemh("sim/hart_vectors.txt", vec_mem);
        // Lines end at the first unfilled or all-zero instruction word
        while (num_vec < MAX_VEC && !$isunknown(vec_mem[num_vec*NUM_FIELDS])
               && vec_mem[num_vec*NUM_FIELDS] != '0) begin
            num_vec++;
        end
        loaded = 1'b1;
        if (num_vec == 0) begin
            $display("No vectors could be read from sim/hart_vectors.txt");
            err_count++;
        end

        // Reset held for 8 cycles with stores and loads on the fetch bus
        errs = err_count;
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            #1;
            imem_rdata = (i % 2 == 0) ? IDLE_STORE : IDLE_LOAD;
            #(CLK_PERIOD - 2);
            compare_word("retire_valid in reset", to_word(retire_valid), '0);
            compare_word("dmem_wen in reset", to_word(dmem_wen), '0);
            compare_word("dmem_ren in reset", to_word(dmem_ren), '0);
        end
        report_test("Reset", errs);
        rst_n = 1'b1;

        // Drive 1 ns after the edge, sample 1 ns before the next one
        for (int n = 0; n < num_vec; n++) begin
            @(posedge clk);
            #1;
            imem_rdata = vec_mem[n*NUM_FIELDS];
            dmem_rdata = vec_mem[n*NUM_FIELDS + 1];
            #(CLK_PERIOD - 2);
            errs = err_count;
            check_outputs(n, last_next_pc);
            last_next_pc = vec_mem[n*NUM_FIELDS + 3];
            report_test($sformatf("Vector %0d at pc %h", n, vec_mem[n*NUM_FIELDS + 2]), errs);
        end

        $display("Tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (err_count == 0 && tests_failed == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Watchdog sized from the number of vector lines
    initial begin
        wait (loaded);
        #((num_vec + 20) * CLK_PERIOD * 2);
        $display("Run timed out before all vectors were checked");
        $display("Checks failed");
        $finish;
    end

endmodule

//--- src/alu.sv
// 32-bit ALU with branch comparison
// Purely combinational. o_result carries the selected operation,
// o_br_taken the selected branch condition on the same two operands.
// Shift amounts come from the low 5 bits of operand 2.

`timescale 1ns/1ps

module alu import rv_pkg::*; (
    input  alu_op_e            i_alu_op,
    input  br_cond_e           i_br_cond,
    input  logic [XLEN-1:0]    i_op1,
    input  logic [XLEN-1:0]    i_op2,
    output logic [XLEN-1:0]    o_result,
    output logic               o_br_taken
);

    logic [4:0] shamt;
    logic       eq;
    logic       lt_s;                            // Signed less than
    logic       lt_u;                            // Unsigned less than

    assign shamt = i_op2[4:0];

    // Compare once, shared by SLT/SLTU and all six branches
    assign eq   = (i_op1 == i_op2);
    assign lt_s = ($signed(i_op1) < $signed(i_op2));
    assign lt_u = (i_op1 < i_op2);

    ////////////////////////////////////////////////////////////////////////////
    // Result
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        case (i_alu_op)
            ALU_ADD:    o_result = i_op1 + i_op2;   // Carry dropped
            ALU_SUB:    o_result = i_op1 - i_op2;
            ALU_AND:    o_result = i_op1 & i_op2;
            ALU_OR:     o_result = i_op1 | i_op2;
            ALU_XOR:    o_result = i_op1 ^ i_op2;
            ALU_SLL:    o_result = i_op1 << shamt;
            ALU_SRL:    o_result = i_op1 >> shamt;
            ALU_SRA:    o_result = $unsigned($signed(i_op1) >>> shamt);
            ALU_SLT:    o_result = {{(XLEN-1){1'b0}}, lt_s};
            ALU_SLTU:   o_result = {{(XLEN-1){1'b0}}, lt_u};
            ALU_PASS_B: o_result = i_op2;           // LUI
            default:    o_result = '0;
        endcase
    end

    // Branch condition
    always_comb begin
        case (i_br_cond)
            BR_EQ:   o_br_taken = eq;
            BR_NE:   o_br_taken = ~eq;
            BR_LT:   o_br_taken = lt_s;
            BR_GE:   o_br_taken = ~lt_s;
            BR_LTU:  o_br_taken = lt_u;
            BR_GEU:  o_br_taken = ~lt_u;
            default: o_br_taken = 1'b0;
        endcase
    end

endmodule

//--- src/inst_decode.sv
// Instruction decoder for the single-cycle core
// Purely combinational. Takes the fetched word and produces register
// addresses, the immediate, ALU and operand selects, branch controls and
// the memory levels. Write and memory enables are held low while the core
// is not executing (i_valid low).

`timescale 1ns/1ps

module inst_decode import rv_pkg::*; (
    input  inst_u                   i_inst,
    input  logic                    i_valid,     // Core is executing this cycle
    output logic [REG_ADDR_W-1:0]   o_rs1_addr,
    output logic [REG_ADDR_W-1:0]   o_rs2_addr,
    output logic [REG_ADDR_W-1:0]   o_rd_addr,
    output logic                    o_rd_wen,
    output logic [XLEN-1:0]         o_imm,
    output alu_op_e                 o_alu_op,
    output op1_sel_e                o_op1_sel,
    output logic                    o_op2_imm,   // Operand 2 from immediate
    output logic                    o_branch,
    output br_cond_e                o_br_cond,
    output logic                    o_mem_read,
    output logic                    o_mem_write
);

    logic [2:0]       funct3;
    logic             alt_bit;                   // funct7 bit 5
    logic             is_reg_op;
    logic [XLEN-1:0]  imm_i;
    logic [XLEN-1:0]  imm_s;
    logic [XLEN-1:0]  imm_b;
    logic [XLEN-1:0]  imm_u;
    alu_op_e          arith_op;                  // Op from funct3/funct7
    logic             rd_wen_raw;
    logic             mem_read_raw;
    logic             mem_write_raw;

    // Register fields sit in the same place for every format
    assign o_rs1_addr = i_inst.r_fmt.rs1;
    assign o_rs2_addr = i_inst.r_fmt.rs2;
    assign o_rd_addr  = i_inst.r_fmt.rd;
    assign funct3     = i_inst.r_fmt.funct3;
    assign alt_bit    = i_inst.r_fmt.funct7[5];
    assign is_reg_op  = (i_inst.r_fmt.opcode == OP_REG);

    ////////////////////////////////////////////////////////////////////////////
    // Immediate formats, all sign extended from bit 31
    ////////////////////////////////////////////////////////////////////////////
    assign imm_i = {{20{i_inst.i_fmt.imm_11_0[11]}}, i_inst.i_fmt.imm_11_0};
    assign imm_s = {{20{i_inst.s_fmt.imm_11_5[6]}}, i_inst.s_fmt.imm_11_5,
                    i_inst.s_fmt.imm_4_0};
    assign imm_b = {{19{i_inst.b_fmt.imm_12}}, i_inst.b_fmt.imm_12, i_inst.b_fmt.imm_11,
                    i_inst.b_fmt.imm_10_5, i_inst.b_fmt.imm_4_1, 1'b0};
    assign imm_u = {i_inst.u_fmt.imm_31_12, 12'b0};

    // Arithmetic op, shared by R and I type
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (is_reg_op && alt_bit) ? ALU_SUB : ALU_ADD; // No SUBI
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = alt_bit ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        rd_wen_raw    = 1'b0;                    // Unknown opcodes do nothing
        mem_read_raw  = 1'b0;
        mem_write_raw = 1'b0;
        o_imm         = imm_i;
        o_alu_op      = ALU_ADD;
        o_op1_sel     = OP1_REG;
        o_op2_imm     = 1'b0;
        o_branch      = 1'b0;
        o_br_cond     = BR_EQ;
        case (i_inst.r_fmt.opcode)
            OP_REG: begin
                rd_wen_raw = 1'b1;
                o_alu_op   = arith_op;
            end
            OP_IMM: begin
                rd_wen_raw = 1'b1;
                o_alu_op   = arith_op;
                o_op2_imm  = 1'b1;
            end
            OP_LOAD: begin                       // Word access only
                rd_wen_raw   = 1'b1;
                mem_read_raw = 1'b1;
                o_op2_imm    = 1'b1;
            end
            OP_STORE: begin
                mem_write_raw = 1'b1;
                o_imm         = imm_s;
                o_op2_imm     = 1'b1;
            end
            OP_BRANCH: begin
                o_branch = 1'b1;
                o_imm    = imm_b;                // Target built in result stage
                case (funct3)
                    3'b001:  o_br_cond = BR_NE;
                    3'b100:  o_br_cond = BR_LT;
                    3'b101:  o_br_cond = BR_GE;
                    3'b110:  o_br_cond = BR_LTU;
                    3'b111:  o_br_cond = BR_GEU;
                    default: o_br_cond = BR_EQ;
                endcase
            end
            OP_LUI: begin
                rd_wen_raw = 1'b1;
                o_imm      = imm_u;
                o_op1_sel  = OP1_ZERO;
                o_op2_imm  = 1'b1;
                o_alu_op   = ALU_PASS_B;
            end
            OP_AUIPC: begin
                rd_wen_raw = 1'b1;
                o_imm      = imm_u;
                o_op1_sel  = OP1_PC;
                o_op2_imm  = 1'b1;
            end
            default: ;
        endcase
    end

    assign o_rd_wen    = rd_wen_raw & i_valid;
    assign o_mem_read  = mem_read_raw & i_valid;
    assign o_mem_write = mem_write_raw & i_valid;

endmodule

//--- src/reg_file.sv
// Integer register file, 32 entries of XLEN bits
// Two combinational read ports and one write port clocked on the rising
// edge. x0 is hardwired to zero. No write-to-read bypass, a read of the
// register being written returns the old value.

`timescale 1ns/1ps

module reg_file import rv_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [REG_ADDR_W-1:0]   i_rs1_addr,
    input  logic [REG_ADDR_W-1:0]   i_rs2_addr,
    input  logic [REG_ADDR_W-1:0]   i_rd_addr,
    input  logic                    i_rd_wen,
    input  logic [XLEN-1:0]         i_rd_wdata,
    output logic [XLEN-1:0]         o_rs1_data,
    output logic [XLEN-1:0]         o_rs2_data
);

    logic [XLEN-1:0] regs [1:31];               // No storage for x0

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_rd_wen && (i_rd_addr != '0)) begin
            regs[i_rd_addr] <= i_rd_wdata;      // Writes to x0 dropped
        end
    end

    // Reads are combinational
    assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
    assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

endmodule

//--- src/result_stage.sv
// Result stage: PC, next-PC choice, write-back data and the valid flag
// The valid flag rises on the first clock edge after reset and stays
// high. The PC holds RESET_ADDR until valid is set, so the first
// executed instruction is the one at RESET_ADDR.

`timescale 1ns/1ps

module result_stage import rv_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_ADDR = '0
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               i_branch,
    input  logic               i_br_taken,
    input  logic [XLEN-1:0]    i_imm,            // B immediate on branches
    input  logic               i_mem_read,
    input  logic [XLEN-1:0]    i_alu_result,
    input  logic [XLEN-1:0]    i_load_data,
    output logic [XLEN-1:0]    o_pc,
    output logic [XLEN-1:0]    o_next_pc,
    output logic [XLEN-1:0]    o_rd_wdata,
    output logic               o_valid
);

    logic [XLEN-1:0] pc_q;
    logic            valid_q;

    // Taken branch jumps relative to this PC, everything else falls through
    assign o_next_pc = (i_branch && i_br_taken) ? (pc_q + i_imm) : (pc_q + 32'd4);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q    <= RESET_ADDR;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b1;
            if (valid_q) pc_q <= o_next_pc;      // Hold PC on the first edge
        end
    end

    assign o_pc       = pc_q;
    assign o_valid    = valid_q;
    assign o_rd_wdata = i_mem_read ? i_load_data : i_alu_result;  // Load or ALU

endmodule

//--- src/rv_hart.sv
// Top level of the single-cycle RV32I core
// Instruction and data memories sit outside and answer combinationally.
// One instruction retires per clock; the retire port reports it in the
// same cycle it executes.

`timescale 1ns/1ps

module rv_hart import rv_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_ADDR = '0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    output logic [XLEN-1:0]         o_imem_raddr,
    input  logic [XLEN-1:0]         i_imem_rdata,
    output logic [XLEN-1:0]         o_dmem_addr,
    output logic                    o_dmem_ren,
    output logic                    o_dmem_wen,
    output logic [XLEN-1:0]         o_dmem_wdata,
    input  logic [XLEN-1:0]         i_dmem_rdata,
    output logic                    o_retire_valid,
    output logic [XLEN-1:0]         o_retire_inst,
    output logic [XLEN-1:0]         o_retire_pc,
    output logic [XLEN-1:0]         o_retire_next_pc,
    output logic [REG_ADDR_W-1:0]   o_retire_rd_waddr,
    output logic [XLEN-1:0]         o_retire_rd_wdata
);

    inst_u                  inst;
    logic                   valid;
    logic [REG_ADDR_W-1:0]  rs1_addr, rs2_addr, rd_addr;
    logic                   rd_wen;
    logic [XLEN-1:0]        imm, rs1_data, rs2_data;
    logic [XLEN-1:0]        op1, op2;
    logic [XLEN-1:0]        alu_result, rd_wdata, pc, next_pc;
    alu_op_e                alu_op;
    op1_sel_e               op1_sel;
    logic                   op2_imm;
    logic                   branch, br_taken;
    br_cond_e               br_cond;
    logic                   mem_read, mem_write;

    assign inst = i_imem_rdata;

    inst_decode i_inst_decode (
        .i_inst(inst), .i_valid(valid),
        .o_rs1_addr(rs1_addr), .o_rs2_addr(rs2_addr), .o_rd_addr(rd_addr),
        .o_rd_wen(rd_wen), .o_imm(imm), .o_alu_op(alu_op), .o_op1_sel(op1_sel),
        .o_op2_imm(op2_imm), .o_branch(branch), .o_br_cond(br_cond),
        .o_mem_read(mem_read), .o_mem_write(mem_write)
    );

    reg_file i_reg_file (
        .clk(clk), .rst_n(rst_n),
        .i_rs1_addr(rs1_addr), .i_rs2_addr(rs2_addr), .i_rd_addr(rd_addr),
        .i_rd_wen(rd_wen), .i_rd_wdata(rd_wdata),
        .o_rs1_data(rs1_data), .o_rs2_data(rs2_data)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Operand muxes
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        case (op1_sel)
            OP1_ZERO: op1 = '0;                  // LUI
            OP1_PC:   op1 = pc;                  // AUIPC
            default:  op1 = rs1_data;
        endcase
    end
    assign op2 = op2_imm ? imm : rs2_data;

    alu i_alu (
        .i_alu_op(alu_op), .i_br_cond(br_cond), .i_op1(op1), .i_op2(op2),
        .o_result(alu_result), .o_br_taken(br_taken)
    );

    result_stage #(.RESET_ADDR(RESET_ADDR)) i_result_stage (
        .clk(clk), .rst_n(rst_n),
        .i_branch(branch), .i_br_taken(br_taken), .i_imm(imm),
        .i_mem_read(mem_read), .i_alu_result(alu_result), .i_load_data(i_dmem_rdata),
        .o_pc(pc), .o_next_pc(next_pc), .o_rd_wdata(rd_wdata), .o_valid(valid)
    );

    // Memory ports
    assign o_imem_raddr = pc;
    assign o_dmem_addr  = alu_result;            // rs1 + offset on loads/stores
    assign o_dmem_wdata = rs2_data;
    assign o_dmem_ren   = mem_read;
    assign o_dmem_wen   = mem_write;

    // Retire port
    assign o_retire_valid    = valid;
    assign o_retire_inst     = i_imem_rdata;
    assign o_retire_pc       = pc;
    assign o_retire_next_pc  = next_pc;
    assign o_retire_rd_waddr = rd_wen ? rd_addr : '0;  // Zero when nothing is written
    assign o_retire_rd_wdata = rd_wdata;

endmodule

//--- src/rv_pkg.sv
// Shared definitions for the single-cycle RV32I core
// Holds widths, major opcodes, ALU and branch encodings and the
// instruction word union. RTL files pull it in with a wildcard import.

package rv_pkg;

    localparam int XLEN       = 32;         // Data and address width
    localparam int REG_ADDR_W = 5;          // Register index width

    ////////////////////////////////////////////////////////////////////////////
    // Major opcodes
    ////////////////////////////////////////////////////////////////////////////
    localparam logic [6:0] OP_REG    = 7'b011_0011;  // R type arithmetic
    localparam logic [6:0] OP_IMM    = 7'b001_0011;  // I type arithmetic
    localparam logic [6:0] OP_LOAD   = 7'b000_0011;
    localparam logic [6:0] OP_STORE  = 7'b010_0011;
    localparam logic [6:0] OP_BRANCH = 7'b110_0011;
    localparam logic [6:0] OP_LUI    = 7'b011_0111;
    localparam logic [6:0] OP_AUIPC  = 7'b001_0111;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
        ALU_PASS_B                          // Operand 2 straight through
    } alu_op_e;

    // Codes match funct3 of the branch instructions
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } br_cond_e;

    typedef enum logic [1:0] {
        OP1_REG,                            // rs1 data
        OP1_ZERO,                           // LUI
        OP1_PC                              // AUIPC
    } op1_sel_e;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction word, one view per encoding format
    ////////////////////////////////////////////////////////////////////////////
    typedef union packed {
        struct packed {
            logic [6:0] funct7; logic [4:0] rs2; logic [4:0] rs1;
            logic [2:0] funct3; logic [4:0] rd;  logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm_11_0; logic [4:0] rs1;
            logic [2:0]  funct3;   logic [4:0] rd;  logic [6:0] opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_11_5; logic [4:0] rs2;      logic [4:0] rs1;
            logic [2:0] funct3;   logic [4:0] imm_4_0;  logic [6:0] opcode;
        } s_fmt;
        struct packed {
            logic       imm_12;  logic [5:0] imm_10_5; logic [4:0] rs2;
            logic [4:0] rs1;     logic [2:0] funct3;   logic [3:0] imm_4_1;
            logic       imm_11;  logic [6:0] opcode;
        } b_fmt;
        struct packed {
            logic [19:0] imm_31_12; logic [4:0] rd; logic [6:0] opcode;
        } u_fmt;
    } inst_u;

endpackage
